/* rtl/dispatchPkg.sv */
// dispatch stage package with capacities, widths, unit and lane enums, and packet structs
package dispatchPkg;

	// group size and its index width
	localparam int dispatchWidth    = 4;
	localparam int dispatchWidthLog = 2;

	// back-end capacities, each counter is one bit wider than its index
	localparam int issueQueueSize   = 32;
	localparam int issueQueueCntW   = 6;
	localparam int activeListSize   = 64;
	localparam int activeListCntW   = 7;
	localparam int activeListIdW    = 6;
	localparam int lsqSize          = 16;
	localparam int lsqCntW          = 5;
	localparam int lsqIdW           = 4;

	// payload widths
	localparam int pcW              = 32;
	localparam int instW            = 32;
	localparam int phyRegW          = 7;
	localparam int seqNoW           = 8;
	localparam int causeW           = 4;

	// simple ALU work rotates over this many lanes
	localparam int numSimpleLanes   = 2;
	localparam int simplePtrW       = $clog2(numSimpleLanes);

	// functional unit class coming out of decode and rename
	typedef enum logic [1:0] {
		fuSimple,
		fuComplex,
		fuControl,
		fuMemory
	} fuTypeE;

	// execution lane written into the issue queue entry
	typedef enum logic [2:0] {
		laneMem     = 3'd0,
		laneCtrl    = 3'd1,
		laneComplex = 3'd2,
		laneSimple0 = 3'd3,
		laneSimple1 = 3'd4
	} exeLaneE;

	// one renamed instruction as delivered by the rename stage
	typedef struct packed {
		logic                valid;
		logic [seqNoW-1:0]   seqNo;
		logic [pcW-1:0]      pc;
		logic [instW-1:0]    inst;
		fuTypeE              fu;
		logic [phyRegW-1:0]  phyDest;
		logic                phyDestValid;
		logic [phyRegW-1:0]  phySrc1;
		logic                phySrc1Valid;
		logic [phyRegW-1:0]  phySrc2;
		logic                phySrc2Valid;
		logic                isLoad;
		logic                isStore;
		logic                isAtom;
		logic                exception;
		logic [causeW-1:0]   exceptionCause;
	} disPktT;

	// issue queue entry, carries the steered lane and the back-end indices
	typedef struct packed {
		logic                     valid;
		logic [seqNoW-1:0]        seqNo;
		logic [pcW-1:0]           pc;
		logic [instW-1:0]         inst;
		exeLaneE                  lane;
		logic                     isSimple;
		logic [phyRegW-1:0]       phyDest;
		logic                     phyDestValid;
		logic [phyRegW-1:0]       phySrc1;
		logic                     phySrc1Valid;
		logic [phyRegW-1:0]       phySrc2;
		logic                     phySrc2Valid;
		logic [activeListIdW-1:0] alId;
		logic [lsqIdW-1:0]        lsqId;
		logic                     isLoad;
		logic                     isStore;
		logic                     isAtom;
	} iqPktT;

	// active list entry, also written for excepting instructions
	typedef struct packed {
		logic                valid;
		logic [seqNoW-1:0]   seqNo;
		logic [pcW-1:0]      pc;
		logic [phyRegW-1:0]  phyDest;
		logic                phyDestValid;
		logic                isLoad;
		logic                isStore;
		logic                isAtom;
		logic                exception;
		logic [causeW-1:0]   exceptionCause;
	} alPktT;

	// load/store queue entry
	typedef struct packed {
		logic                valid;
		logic [seqNoW-1:0]   seqNo;
		logic                isLoad;
		logic                isStore;
		logic                isAtom;
	} lsqPktT;

	// oldest excepting instruction of the group
	typedef struct packed {
		logic                     valid;
		logic [seqNoW-1:0]        seqNo;
		logic [activeListIdW-1:0] alId;
		logic [causeW-1:0]        exceptionCause;
	} excptPktT;

	// per-lane groups, lane 0 is the oldest instruction
	typedef disPktT  [dispatchWidth-1:0] disGroupT;
	typedef iqPktT   [dispatchWidth-1:0] iqGroupT;
	typedef alPktT   [dispatchWidth-1:0] alGroupT;
	typedef lsqPktT  [dispatchWidth-1:0] lsqGroupT;
	typedef exeLaneE [dispatchWidth-1:0] laneGroupT;
	typedef logic    [dispatchWidth-1:0][activeListIdW-1:0] alIdGroupT;
	typedef logic    [dispatchWidth-1:0][lsqIdW-1:0]        lsqIdGroupT;

	// current fill levels of the back-end structures
	typedef struct packed {
		logic [issueQueueCntW-1:0] issueQueueCnt;
		logic [activeListCntW-1:0] activeListCnt;
		logic [lsqCntW-1:0]        loadQueueCnt;
		logic [lsqCntW-1:0]        storeQueueCnt;
	} occupancyT;

endpackage

/* rtl/resourceCheck.sv */
// resource check with load/store counting, capacity compare, stall, atomic hold and dispatch-ready
module resourceCheck import dispatchPkg::*; (
	input  disGroupT  disGroup_i,
	input  occupancyT occupancy_i,
	input  logic      renameReady_i,
	input  logic      iqFreeReady_i,
	output logic      stall_o,
	output logic      dispatchReady_o,
	output logic      backEndFull_o
);

	// a count of up to dispatchWidth needs one bit more than the lane index
	logic [dispatchWidthLog:0] loadCnt;
	logic [dispatchWidthLog:0] storeCnt;
	logic                      iqStall;
	logic                      alStall;
	logic                      loadStall;
	logic                      storeStall;
	logic                      atomHold;

	// only valid lanes take a queue entry
	always_comb
	begin
		loadCnt  = '0;
		storeCnt = '0;
		for (int i = 0; i < dispatchWidth; i++)
		begin
			loadCnt  = loadCnt + (dispatchWidthLog + 1)'(disGroup_i[i].valid & disGroup_i[i].isLoad);
			storeCnt = storeCnt + (dispatchWidthLog + 1)'(disGroup_i[i].valid & disGroup_i[i].isStore);
		end
	end

	// issue queue and active list reserve a full group, the sums get one extra bit
	assign iqStall = (({1'b0, occupancy_i.issueQueueCnt} + (issueQueueCntW + 1)'(dispatchWidth))
		> (issueQueueCntW + 1)'(issueQueueSize)) | ~iqFreeReady_i;
	assign alStall = ({1'b0, occupancy_i.activeListCnt} + (activeListCntW + 1)'(dispatchWidth))
		> (activeListCntW + 1)'(activeListSize);

	// load and store queues only reserve what the group really uses
	assign loadStall = ({1'b0, occupancy_i.loadQueueCnt} + (lsqCntW + 1)'(loadCnt))
		> (lsqCntW + 1)'(lsqSize);
	assign storeStall = ({1'b0, occupancy_i.storeQueueCnt} + (lsqCntW + 1)'(storeCnt))
		> (lsqCntW + 1)'(lsqSize);

	assign stall_o = iqStall | alStall | loadStall | storeStall;

	// an atomic in lane 0 holds the front end until the load/store queue has drained
	assign atomHold = disGroup_i[0].valid & disGroup_i[0].isAtom
		& ((occupancy_i.loadQueueCnt != '0) | (occupancy_i.storeQueueCnt != '0));

	// the group is taken this cycle, back-end queues write on this
	assign dispatchReady_o = renameReady_i & ~stall_o;

	// the atomic hold only stops the front end, the current group still goes out
	assign backEndFull_o = stall_o | atomHold;

endmodule

/* rtl/exePipeScheduler.sv */
// execution lane scheduler with fixed steering and the rotating simple-lane pointer
module exePipeScheduler import dispatchPkg::*; (
	input  logic                     clk,
	input  logic                     arstN_i,
	input  logic                     recoverFlag_i,
	input  logic                     dispatchReady_i,
	input  disGroupT                 disGroup_i,
	output laneGroupT                lanes_o,
	output logic [dispatchWidth-1:0] isSimple_o
);

	// simple lane that the next valid simple instruction will take
	logic [simplePtrW-1:0]     simplePtr;
	logic [simplePtrW-1:0]     nextPtr;
	// number of valid simple instructions in the group
	logic [dispatchWidthLog:0] simpleCnt;

	// steer each lane, simple work alternates starting at the pointer
	always_comb
	begin
		int unsigned k;
		int unsigned slot;
		k    = 0;
		slot = 0;
		for (int i = 0; i < dispatchWidth; i++)
		begin
			isSimple_o[i] = disGroup_i[i].fu == fuSimple;
			case (disGroup_i[i].fu)
				fuMemory:
					lanes_o[i] = laneMem;
				fuControl:
					lanes_o[i] = laneCtrl;
				fuComplex:
					lanes_o[i] = laneComplex;
				default:
				begin
					// k is the rank of this instruction among the valid simple ones
					slot = (simplePtr + k) % numSimpleLanes;
					lanes_o[i] = (slot == 0) ? laneSimple0 : laneSimple1;
					// an invalid slot still gets a lane but does not use up a turn
					if (disGroup_i[i].valid)
						k = k + 1;
				end
			endcase
		end
		simpleCnt = (dispatchWidthLog + 1)'(k);
	end

	// pointer moves past every simple instruction that was dispatched
	assign nextPtr = simplePtrW'((simplePtr + simpleCnt) % numSimpleLanes);

	// recovery restarts the rotation at the first simple lane
	always_ff @(posedge clk or negedge arstN_i)
	begin
		if (!arstN_i)
			simplePtr <= '0;
		else if (recoverFlag_i)
			simplePtr <= '0;
		else if (dispatchReady_i)
			simplePtr <= nextPtr;
	end

endmodule

/* rtl/packetBuilder.sv */
// packet builder for issue queue, active list and load/store queue, plus the exception encoder
module packetBuilder import dispatchPkg::*; (
	input  disGroupT                 disGroup_i,
	input  alIdGroupT                alId_i,
	input  lsqIdGroupT               lsqId_i,
	input  laneGroupT                lanes_i,
	input  logic [dispatchWidth-1:0] isSimple_i,
	input  logic                     stall_i,
	output iqGroupT                  iqGroup_o,
	output alGroupT                  alGroup_o,
	output lsqGroupT                 lsqGroup_o,
	output excptPktT                 excptPkt_o
);

	// valid and excepting lanes
	logic [dispatchWidth-1:0]    excVec;
	// index of the oldest excepting lane
	logic [dispatchWidthLog-1:0] excId;

	// issue queue entries, an excepting instruction never issues
	always_comb
	begin
		for (int i = 0; i < dispatchWidth; i++)
		begin
			iqGroup_o[i].valid        = disGroup_i[i].valid & ~stall_i & ~disGroup_i[i].exception;
			iqGroup_o[i].seqNo        = disGroup_i[i].seqNo;
			iqGroup_o[i].pc           = disGroup_i[i].pc;
			iqGroup_o[i].inst         = disGroup_i[i].inst;
			iqGroup_o[i].lane         = lanes_i[i];
			iqGroup_o[i].isSimple     = isSimple_i[i];
			iqGroup_o[i].phyDest      = disGroup_i[i].phyDest;
			iqGroup_o[i].phyDestValid = disGroup_i[i].phyDestValid;
			iqGroup_o[i].phySrc1      = disGroup_i[i].phySrc1;
			iqGroup_o[i].phySrc1Valid = disGroup_i[i].phySrc1Valid;
			iqGroup_o[i].phySrc2      = disGroup_i[i].phySrc2;
			iqGroup_o[i].phySrc2Valid = disGroup_i[i].phySrc2Valid;
			iqGroup_o[i].alId         = alId_i[i];
			iqGroup_o[i].lsqId        = lsqId_i[i];
			iqGroup_o[i].isLoad       = disGroup_i[i].isLoad;
			iqGroup_o[i].isStore      = disGroup_i[i].isStore;
			iqGroup_o[i].isAtom       = disGroup_i[i].isAtom;
		end
	end

	// active list entries are written even on exception so that commit can raise it in order
	always_comb
	begin
		for (int i = 0; i < dispatchWidth; i++)
		begin
			alGroup_o[i].valid          = disGroup_i[i].valid & ~stall_i;
			alGroup_o[i].seqNo          = disGroup_i[i].seqNo;
			alGroup_o[i].pc             = disGroup_i[i].pc;
			alGroup_o[i].phyDest        = disGroup_i[i].phyDest;
			alGroup_o[i].phyDestValid   = disGroup_i[i].phyDestValid;
			alGroup_o[i].isLoad         = disGroup_i[i].isLoad;
			alGroup_o[i].isStore        = disGroup_i[i].isStore;
			alGroup_o[i].isAtom         = disGroup_i[i].isAtom;
			alGroup_o[i].exception      = disGroup_i[i].exception;
			alGroup_o[i].exceptionCause = disGroup_i[i].exceptionCause;
		end
	end

	// load/store queue entries, masked like the issue queue
	always_comb
	begin
		for (int i = 0; i < dispatchWidth; i++)
		begin
			lsqGroup_o[i].valid   = disGroup_i[i].valid & ~stall_i & ~disGroup_i[i].exception;
			lsqGroup_o[i].seqNo   = disGroup_i[i].seqNo;
			lsqGroup_o[i].isLoad  = disGroup_i[i].isLoad;
			lsqGroup_o[i].isStore = disGroup_i[i].isStore;
			lsqGroup_o[i].isAtom  = disGroup_i[i].isAtom;
		end
	end

	// scan from the youngest lane down so the oldest excepting lane is kept
	always_comb
	begin
		excId = '0;
		for (int i = dispatchWidth - 1; i >= 0; i--)
		begin
			excVec[i] = disGroup_i[i].valid & disGroup_i[i].exception;
			if (excVec[i])
				excId = dispatchWidthLog'(i);
		end
	end

	// exception packet is held back under stall, the active list entry is not written yet
	assign excptPkt_o.valid          = (|excVec) & ~stall_i;
	assign excptPkt_o.seqNo          = disGroup_i[excId].seqNo;
	assign excptPkt_o.alId           = alId_i[excId];
	assign excptPkt_o.exceptionCause = disGroup_i[excId].exceptionCause;

endmodule

/* rtl/dispatch.sv */
// dispatch stage top level joining resource check, lane scheduler and packet builder
module dispatch import dispatchPkg::*; (
	input  logic       clk,
	input  logic       arstN_i,
	// rename has a group waiting
	input  logic       renameReady_i,
	// issue queue free list can hand out a full group of entries
	input  logic       iqFreeReady_i,
	input  logic       recoverFlag_i,
	input  disGroupT   disGroup_i,
	input  alIdGroupT  alId_i,
	input  lsqIdGroupT lsqId_i,
	input  occupancyT  occupancy_i,
	output iqGroupT    iqGroup_o,
	output alGroupT    alGroup_o,
	output lsqGroupT   lsqGroup_o,
	output excptPktT   excptPkt_o,
	// back-end queues write only while this is high
	output logic       dispatchReady_o,
	// stops instruction buffer read and rename
	output logic       backEndFull_o
);

	logic                     stall;
	laneGroupT                lanes;
	logic [dispatchWidth-1:0] isSimple;

	// decides stall, dispatch-ready and the front-end hold
	resourceCheck resourceCheck_i (
		.disGroup_i      (disGroup_i),
		.occupancy_i     (occupancy_i),
		.renameReady_i   (renameReady_i),
		.iqFreeReady_i   (iqFreeReady_i),
		.stall_o         (stall),
		.dispatchReady_o (dispatchReady_o),
		.backEndFull_o   (backEndFull_o)
	);

	// the pointer advances only on groups that are really taken
	exePipeScheduler exePipeScheduler_i (
		.clk             (clk),
		.arstN_i         (arstN_i),
		.recoverFlag_i   (recoverFlag_i),
		.dispatchReady_i (dispatchReady_o),
		.disGroup_i      (disGroup_i),
		.lanes_o         (lanes),
		.isSimple_o      (isSimple)
	);

	// builds all outgoing packets in the same cycle
	packetBuilder packetBuilder_i (
		.disGroup_i (disGroup_i),
		.alId_i     (alId_i),
		.lsqId_i    (lsqId_i),
		.lanes_i    (lanes),
		.isSimple_i (isSimple),
		.stall_i    (stall),
		.iqGroup_o  (iqGroup_o),
		.alGroup_o  (alGroup_o),
		.lsqGroup_o (lsqGroup_o),
		.excptPkt_o (excptPkt_o)
	);

endmodule

/* bench/dispatchTb.sv */
// testbench for the dispatch stage with reference rules, stimulus tasks and concurrent checks
module dispatchTb import dispatchPkg::*; ();

	logic clk;
	logic arstN_i, renameReady_i, iqFreeReady_i, recoverFlag_i;
	disGroupT disGroup_i;
	alIdGroupT alId_i;
	lsqIdGroupT lsqId_i;
	occupancyT occupancy_i;
	iqGroupT iqGroup_o;
	alGroupT alGroup_o;
	lsqGroupT lsqGroup_o;
	excptPktT excptPkt_o;
	logic dispatchReady_o, backEndFull_o;

	// reference model state and expectations
	logic modelPtr;
	logic expReady, expFull, expStall, expExcValid, fieldsOk, excOk;
	logic [dispatchWidth-1:0] expIqV, expAlV, gotIqV, gotAlV, gotLsqV, laneOk;
	int expExcLane, simpleSeen, errCount, passTests, failTests, errBefore;

	dispatch dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// expected outputs straight from the resource, steering and packet rules
	always_comb
	begin
		int loads;
		int stores;
		int k;
		exeLaneE want;
		loads = 0;
		stores = 0;
		k = 0;
		expExcValid = 1'b0;
		expExcLane = 0;
		for (int i = 0; i < dispatchWidth; i++)
		begin
			loads += int'(disGroup_i[i].valid && disGroup_i[i].isLoad);
			stores += int'(disGroup_i[i].valid && disGroup_i[i].isStore);
		end
		expStall = (int'(occupancy_i.issueQueueCnt) + dispatchWidth > issueQueueSize)
			|| !iqFreeReady_i
			|| (int'(occupancy_i.activeListCnt) + dispatchWidth > activeListSize)
			|| (int'(occupancy_i.loadQueueCnt) + loads > lsqSize)
			|| (int'(occupancy_i.storeQueueCnt) + stores > lsqSize);
		expReady = renameReady_i && !expStall;
		expFull = expStall || (disGroup_i[0].valid && disGroup_i[0].isAtom
			&& (occupancy_i.loadQueueCnt != 0 || occupancy_i.storeQueueCnt != 0));
		fieldsOk = 1'b1;
		for (int i = dispatchWidth - 1; i >= 0; i--)
		begin
			expAlV[i] = disGroup_i[i].valid && !expStall;
			expIqV[i] = expAlV[i] && !disGroup_i[i].exception;
			gotIqV[i] = iqGroup_o[i].valid;
			gotAlV[i] = alGroup_o[i].valid;
			gotLsqV[i] = lsqGroup_o[i].valid;
			if (disGroup_i[i].valid && disGroup_i[i].exception)
			begin
				expExcValid = !expStall;
				expExcLane = i;
			end
			// every issue queue field is a copy, isSimple marks simple ALU work
			fieldsOk &= iqGroup_o[i].seqNo == disGroup_i[i].seqNo
				&& iqGroup_o[i].pc == disGroup_i[i].pc && iqGroup_o[i].inst == disGroup_i[i].inst
				&& iqGroup_o[i].isSimple == (disGroup_i[i].fu == fuSimple)
				&& iqGroup_o[i].phyDest == disGroup_i[i].phyDest
				&& iqGroup_o[i].phyDestValid == disGroup_i[i].phyDestValid
				&& iqGroup_o[i].phySrc1 == disGroup_i[i].phySrc1
				&& iqGroup_o[i].phySrc1Valid == disGroup_i[i].phySrc1Valid
				&& iqGroup_o[i].phySrc2 == disGroup_i[i].phySrc2
				&& iqGroup_o[i].phySrc2Valid == disGroup_i[i].phySrc2Valid
				&& iqGroup_o[i].alId == alId_i[i] && iqGroup_o[i].lsqId == lsqId_i[i]
				&& iqGroup_o[i].isLoad == disGroup_i[i].isLoad
				&& iqGroup_o[i].isStore == disGroup_i[i].isStore
				&& iqGroup_o[i].isAtom == disGroup_i[i].isAtom;
			fieldsOk &= alGroup_o[i].seqNo == disGroup_i[i].seqNo
				&& alGroup_o[i].pc == disGroup_i[i].pc
				&& alGroup_o[i].phyDest == disGroup_i[i].phyDest
				&& alGroup_o[i].phyDestValid == disGroup_i[i].phyDestValid
				&& alGroup_o[i].isLoad == disGroup_i[i].isLoad
				&& alGroup_o[i].isStore == disGroup_i[i].isStore
				&& alGroup_o[i].isAtom == disGroup_i[i].isAtom
				&& alGroup_o[i].exception == disGroup_i[i].exception
				&& alGroup_o[i].exceptionCause == disGroup_i[i].exceptionCause;
			fieldsOk &= lsqGroup_o[i].seqNo == disGroup_i[i].seqNo
				&& lsqGroup_o[i].isLoad == disGroup_i[i].isLoad
				&& lsqGroup_o[i].isStore == disGroup_i[i].isStore
				&& lsqGroup_o[i].isAtom == disGroup_i[i].isAtom;
		end
		// the k-th valid simple instruction goes by the parity of pointer plus k
		for (int i = 0; i < dispatchWidth; i++)
		begin
			case (disGroup_i[i].fu)
				fuMemory: want = laneMem;
				fuControl: want = laneCtrl;
				fuComplex: want = laneComplex;
				default: want = ((int'(modelPtr) + k) % 2 == 0) ? laneSimple0 : laneSimple1;
			endcase
			if (disGroup_i[i].fu == fuSimple && disGroup_i[i].valid)
				k++;
			laneOk[i] = !disGroup_i[i].valid || iqGroup_o[i].lane == want;
		end
		simpleSeen = k;
		excOk = excptPkt_o.valid == expExcValid && (!expExcValid
			|| (excptPkt_o.seqNo == disGroup_i[expExcLane].seqNo
			&& excptPkt_o.alId == alId_i[expExcLane]
			&& excptPkt_o.exceptionCause == disGroup_i[expExcLane].exceptionCause));
	end

	// model pointer follows the scheduler rule, recovery wins
	always @(posedge clk or negedge arstN_i)
	begin
		if (!arstN_i)
			modelPtr <= 1'b0;
		else if (recoverFlag_i)
			modelPtr <= 1'b0;
		else if (expReady)
			modelPtr <= 1'(int'(modelPtr) + simpleSeen);
	end

	readyCheck: assert property (@(negedge clk) disable iff (!arstN_i) dispatchReady_o == expReady)
	else
	begin
		errCount++;
		$display("Error at %0t: dispatchReady_o is %b, expected %b", $time, dispatchReady_o, expReady);
	end
	fullCheck: assert property (@(negedge clk) disable iff (!arstN_i) backEndFull_o == expFull)
	else
	begin
		errCount++;
		$display("Error at %0t: backEndFull_o is %b, expected %b", $time, backEndFull_o, expFull);
	end
	validCheck: assert property (@(negedge clk) disable iff (!arstN_i)
		gotIqV == expIqV && gotLsqV == expIqV && gotAlV == expAlV)
	else
	begin
		errCount++;
		$display("Error at %0t: packet valids iq %b lsq %b al %b", $time, gotIqV, gotLsqV, gotAlV);
	end
	fieldCheck: assert property (@(negedge clk) disable iff (!arstN_i) fieldsOk)
	else
	begin
		errCount++;
		$display("Error at %0t: a packet field differs from its source", $time);
	end
	laneCheck: assert property (@(negedge clk) disable iff (!arstN_i) &laneOk)
	else
	begin
		errCount++;
		$display("Error at %0t: lane mismatch mask %b, model pointer %b", $time, laneOk, modelPtr);
	end
	excCheck: assert property (@(negedge clk) disable iff (!arstN_i) excOk)
	else
	begin
		errCount++;
		$display("Error at %0t: exception packet wrong, expected lane %0d", $time, expExcLane);
	end

	// random group with plain instructions, callers add atomics and exceptions
	task automatic randomGroup();
		for (int i = 0; i < dispatchWidth; i++)
		begin
			disGroup_i[i] = '0;
			disGroup_i[i].valid = ($urandom_range(3) != 0);
			disGroup_i[i].seqNo = seqNoW'($urandom);
			disGroup_i[i].pc = $urandom;
			disGroup_i[i].inst = $urandom;
			disGroup_i[i].fu = fuTypeE'($urandom_range(3));
			disGroup_i[i].phyDest = phyRegW'($urandom);
			disGroup_i[i].phyDestValid = $urandom_range(1);
			disGroup_i[i].phySrc1 = phyRegW'($urandom);
			disGroup_i[i].phySrc1Valid = $urandom_range(1);
			disGroup_i[i].phySrc2 = phyRegW'($urandom);
			disGroup_i[i].phySrc2Valid = $urandom_range(1);
			disGroup_i[i].isLoad = disGroup_i[i].fu == fuMemory && $urandom_range(1) == 1;
			disGroup_i[i].isStore = disGroup_i[i].fu == fuMemory && !disGroup_i[i].isLoad;
			disGroup_i[i].exceptionCause = causeW'($urandom);
			alId_i[i] = activeListIdW'($urandom);
			lsqId_i[i] = lsqIdW'($urandom);
		end
	endtask

	// move to the drive point just after the next rising edge
	task automatic nextDrive();
		@(posedge clk);
		#10;
	endtask

	task automatic waitReady(input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (!dispatchReady_o && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!dispatchReady_o)
		begin
			$display("timeout: dispatchReady_o never rose within %0d cycles", limit);
			$display("Verification failed");
			$finish;
		end
	endtask

	// the checks of the last drive run on the falling edge, count once they are done
	task automatic closeTest(input string name);
		@(negedge clk);
		#1;
		if (errCount == errBefore)
			passTests++;
		else
			failTests++;
		$display("test %s done with %0d new errors", name, errCount - errBefore);
		errBefore = errCount;
	endtask

	initial
	begin
		void'($urandom(32'h6521));
		errCount = 0;
		errBefore = 0;
		passTests = 0;
		failTests = 0;
		arstN_i = 1'b0;
		renameReady_i = 1'b0;
		iqFreeReady_i = 1'b1;
		recoverFlag_i = 1'b0;
		disGroup_i = '0;
		alId_i = '0;
		lsqId_i = '0;
		occupancy_i = '0;
		repeat (3) @(posedge clk);
		#10;
		arstN_i = 1'b1;

		for (int t = 0; t < 6; t++)
		begin
			nextDrive();
			randomGroup();
			renameReady_i = 1'b1;
			waitReady(4);
		end
		closeTest("ample room");

		for (int c = 0; c < 5; c++)
		begin
			nextDrive();
			randomGroup();
			disGroup_i[0].valid = 1'b1;
			disGroup_i[0].fu = fuMemory;
			disGroup_i[0].isLoad = (c == 2);
			disGroup_i[0].isStore = (c == 3);
			occupancy_i = '0;
			iqFreeReady_i = (c != 4);
			case (c)
				0: occupancy_i.issueQueueCnt = issueQueueCntW'(issueQueueSize - dispatchWidth + 1);
				1: occupancy_i.activeListCnt = activeListCntW'(activeListSize - dispatchWidth + 1);
				2: occupancy_i.loadQueueCnt = lsqCntW'(lsqSize);
				3: occupancy_i.storeQueueCnt = lsqCntW'(lsqSize);
				default: ;
			endcase
		end
		nextDrive();
		occupancy_i = '0;
		iqFreeReady_i = 1'b1;
		closeTest("resource stall");

		nextDrive();
		randomGroup();
		disGroup_i[0].valid = 1'b1;
		disGroup_i[0].isAtom = 1'b1;
		occupancy_i.loadQueueCnt = 5'd2;
		occupancy_i.storeQueueCnt = 5'd1;
		waitReady(4);
		nextDrive();
		occupancy_i = '0;
		closeTest("atomic hold");

		for (int t = 0; t < 12; t++)
		begin
			nextDrive();
			randomGroup();
			for (int i = 0; i < dispatchWidth; i++)
				disGroup_i[i].exception = ($urandom_range(2) == 0);
		end
		closeTest("exception select");

		for (int t = 0; t < 40; t++)
		begin
			nextDrive();
			randomGroup();
			renameReady_i = ($urandom_range(4) != 0);
			occupancy_i.issueQueueCnt = issueQueueCntW'($urandom_range(30));
			occupancy_i.loadQueueCnt = lsqCntW'($urandom_range(16));
			occupancy_i.storeQueueCnt = lsqCntW'($urandom_range(16));
		end
		closeTest("lane rotation");

		// park the pointer at one so a missed clear shows up in the lanes
		nextDrive();
		occupancy_i = '0;
		renameReady_i = 1'b1;
		randomGroup();
		disGroup_i = '0;
		disGroup_i[0].valid = !modelPtr;
		nextDrive();
		// two simple instructions would leave a pointer of one in place without recovery
		disGroup_i[0].valid = 1'b1;
		disGroup_i[1].valid = 1'b1;
		recoverFlag_i = 1'b1;
		nextDrive();
		recoverFlag_i = 1'b0;
		randomGroup();
		disGroup_i[0].valid = 1'b1;
		disGroup_i[0].fu = fuSimple;
		closeTest("recovery");

		$display("tests passed %0d, failed %0d, errors %0d", passTests, failTests, errCount);
		if (errCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* dispatch.f */
rtl/dispatchPkg.sv
rtl/resourceCheck.sv
rtl/exePipeScheduler.sv
rtl/packetBuilder.sv
rtl/dispatch.sv
bench/dispatchTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile the dispatch stage testbench with Verilator and run it.
# The run counts as failed if the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module dispatchTb -f dispatch.f \
	--Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$LOG"
	echo "simulation exited with an error status"
	exit 1
fi

cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
	exit 1
fi

if ! grep -q "Verification passed" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi

exit 0
